/* src/tigerPkg.sv */
package tigerPkg;

	// a register number, register 0 reads as zero and is never a hazard
	typedef logic [4:0] regNumT;

	// decoded control for one instruction, produced by decode outside this block
	// and carried unchanged down the pipe
	typedef struct packed {
		// the instruction writes a general register in WB
		logic regWrite;
		// loads and stores
		logic memRead;
		logic memWrite;
		// unaligned left and right memory accesses, these read rt as data
		logic memL;
		logic memR;
		// control flow
		logic branch;
		// set when the branch compares rs with rt (beq and bne)
		logic branchEqNe;
		logic jump;
		logic regJump;
		logic irqReturn;
		// the second ALU operand comes from the immediate and not from rt
		logic useImm;
		// coprocessor register moves
		logic copRead;
		logic copWrite;
		// multi-cycle multiply, served by the sequencer in Ex
		logic mulOp;
		// the data cache misses on this load, served by the sequencer in MA
		logic memMiss;
		// destination register, only meaningful when regWrite is set
		regNumT writeRegNum;
	} controlT;

	// the register fields of the instruction word plus a tag
	// the tag lets the retire side identify which instruction came out
	typedef struct packed {
		regNumT rs;
		regNumT rt;
		logic [15:0] tag;
	} instrT;

	// everything a stage register carries, the same for all four stages
	typedef struct packed {
		controlT control;
		instrT instr;
	} decodePayloadT;

	// cycles of dStall for one data-cache miss
	localparam int MISS_LATENCY = 6;

	// cycles of stallRqEx for one multiply
	localparam int MUL_LATENCY = 3;

	// width of the shared countdown timer, must hold the larger latency
	localparam int TIMER_WIDTH = 4;

endpackage

/* src/tigerStageReg.sv */
module tigerStageReg #(
	parameter type payloadT = logic [31:0]
) (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic clear,
	input  logic inValid,
	input  payloadT inPayload,
	output logic valid,
	output payloadT payload
);

	// the valid bit is the only control state in the slot
	// hold beats bubble and bubble beats load
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid <= 1'b0;
		end
		else if (stall)
		begin
			valid <= valid;
		end
		else if (clear)
		begin
			valid <= 1'b0;
		end
		else
		begin
			valid <= inValid;
		end
	end

	// payload follows the previous stage whenever the slot is not held
	// on a clear the payload still moves but valid marks it as a bubble
	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			payload <= inPayload;
		end
	end

endmodule

/* src/tigerCountdownTimer.sv */
module tigerCountdownTimer (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [tigerPkg::TIMER_WIDTH-1:0] load,
	output logic busy,
	output logic done
);
	import tigerPkg::*;

	logic [TIMER_WIDTH-1:0] count;

	// a start reloads the count even while an old count is running out
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
		end
		else if (start)
		begin
			count <= load;
		end
		else if (count != '0)
		begin
			count <= count - 1'b1;
		end
	end

	assign busy = count != '0;

	// count of one is the last cycle of the wait
	assign done = count == TIMER_WIDTH'(1);

endmodule

/* src/tigerStallSequencer.sv */
module tigerStallSequencer (
	input  logic clk,
	input  logic reset,
	input  logic maValid,
	input  logic exValid,
	input  tigerPkg::decodePayloadT maPayload,
	input  tigerPkg::decodePayloadT exPayload,
	input  logic stallMA,
	input  logic stallEx,
	input  logic timerBusy,
	input  logic timerDone,
	output logic timerStart,
	output logic [tigerPkg::TIMER_WIDTH-1:0] timerLoad,
	output logic dStall,
	output logic stallRqEx
);
	import tigerPkg::*;

	typedef enum logic [1:0] {Idle, MissWait, MulWait} seqStateT;

	seqStateT state;
	logic maServed;
	logic exServed;
	logic canStart;
	logic missPending;
	logic mulPending;
	logic startMiss;
	logic startMul;

	// a missing load or a multiply that has not been served yet
	assign missPending = maValid && maPayload.control.memRead
		&& maPayload.control.memMiss && !maServed;
	assign mulPending = exValid && exPayload.control.mulOp && !exServed;

	// the timer is shared, a new event may start once it is free or finishing
	assign canStart = !timerBusy || timerDone;

	// the miss in MA wins, the multiply waits behind it in Ex
	assign startMiss = canStart && missPending;
	assign startMul = canStart && mulPending && !missPending;

	assign timerStart = startMiss || startMul;
	assign timerLoad = startMiss ? TIMER_WIDTH'(MISS_LATENCY) : TIMER_WIDTH'(MUL_LATENCY);

	// the stall rises in the cycle the event is seen and drops with done
	assign dStall = startMiss || (state == MissWait && !timerDone);
	assign stallRqEx = startMul || (state == MulWait && !timerDone);

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= Idle;
		else if (startMiss)
			state <= MissWait;
		else if (startMul)
			state <= MulWait;
		else if (timerDone)
			state <= Idle;
	end

	// served flags keep a held instruction from starting a second wait
	// they drop once the stage takes new contents
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			maServed <= 1'b0;
			exServed <= 1'b0;
		end
		else
		begin
			if (startMiss)
				maServed <= 1'b1;
			else if (!stallMA)
				maServed <= 1'b0;
			if (startMul)
				exServed <= 1'b1;
			else if (!stallEx)
				exServed <= 1'b0;
		end
	end

endmodule

/* src/tigerStallLogic.sv */
module tigerStallLogic (
	input  logic deValid,
	input  logic exValid,
	input  logic maValid,
	input  logic wbValid,
	input  tigerPkg::decodePayloadT dePayload,
	input  tigerPkg::decodePayloadT exPayload,
	input  tigerPkg::decodePayloadT maPayload,
	input  tigerPkg::decodePayloadT wbPayload,
	input  logic iStall,
	input  logic cpuHold,
	input  logic exception,
	input  logic dStall,
	input  logic stallRqEx,
	output logic stallDe,
	output logic clearDe,
	output logic stallEx,
	output logic clearEx,
	output logic stallMA,
	output logic clearMA,
	output logic stallWB,
	output logic clearWB,
	output logic fetchReady
);
	import tigerPkg::*;

	// rs is read unless the instruction only redirects control flow
	function automatic logic needsRs(input controlT ctl);
		needsRs = !ctl.irqReturn && !ctl.jump && !ctl.regJump && !ctl.branch;
	endfunction

	// rt is read as an ALU operand when there is no immediate
	// and as store or partial-load data when memory is touched
	function automatic logic needsRt(input controlT ctl);
		logic usesRtData;
		usesRtData = !ctl.useImm || ctl.memWrite || ctl.memL || ctl.memR;
		needsRt = !ctl.irqReturn && !ctl.jump && !ctl.regJump && !ctl.branch
			&& usesRtData;
	endfunction

	logic needStallDe;
	logic needStallEx;
	logic needStallMA;
	logic needStallWB;
	controlT deCtl;
	controlT exCtl;
	controlT maCtl;
	controlT wbCtl;
	logic exWrites;
	logic maWrites;
	logic wbWrites;
	logic rsInEx;
	logic rtInEx;
	logic rsInMA;
	logic rtInMA;
	logic branchEqNeDe;
	logic branchOrJumpDe;
	logic branchHazard;
	logic loadUseHazard;
	logic copHazard;
	logic wbFeedsEx;

	assign deCtl = dePayload.control;
	assign exCtl = exPayload.control;
	assign maCtl = maPayload.control;
	assign wbCtl = wbPayload.control;

	// only a valid instruction that writes a register can produce a hazard
	assign exWrites = exValid && exCtl.regWrite;
	assign maWrites = maValid && maCtl.regWrite;
	assign wbWrites = wbValid && wbCtl.regWrite && wbCtl.writeRegNum != '0;

	// decode source registers matching a destination further down
	// register 0 never matches
	assign rsInEx = dePayload.instr.rs == exCtl.writeRegNum && dePayload.instr.rs != '0;
	assign rtInEx = dePayload.instr.rt == exCtl.writeRegNum && dePayload.instr.rt != '0;
	assign rsInMA = dePayload.instr.rs == maCtl.writeRegNum && dePayload.instr.rs != '0;
	assign rtInMA = dePayload.instr.rt == maCtl.writeRegNum && dePayload.instr.rt != '0;

	// branches resolve in decode, so their operands cannot be forwarded from Ex or MA
	assign branchEqNeDe = deValid && deCtl.branch && deCtl.branchEqNe;
	assign branchOrJumpDe = deValid && (deCtl.branch || deCtl.regJump);

	// beq and bne also compare rt, every branch and register jump reads rs
	assign branchHazard =
		(branchEqNeDe && ((rtInEx && exWrites) || (rtInMA && maWrites)))
		|| (branchOrJumpDe && ((rsInEx && exWrites) || (rsInMA && maWrites)));

	// load data only arrives at the end of MA, one bubble is needed behind the load
	assign loadUseHazard = deValid && exValid && exCtl.memRead
		&& ((rsInEx && needsRs(deCtl)) || (rtInEx && needsRt(deCtl)));

	// coprocessor moves are rare, so any pending coprocessor write blocks a read
	assign copHazard = deValid && deCtl.copRead
		&& ((exValid && exCtl.copWrite)
			|| (maValid && maCtl.copWrite)
			|| (wbValid && wbCtl.copWrite));

	assign needStallDe = branchHazard || loadUseHazard || copHazard;

	// a multiply in progress or a hold from outside the core
	assign needStallEx = stallRqEx || cpuHold;

	// the data cache is still filling the line
	assign needStallMA = dStall;

	// the WB result is forwarded to Ex, if Ex cannot move the result must stay
	// needStallEx and needStallMA are used here instead of stallEx to avoid a loop
	assign wbFeedsEx = exValid
		&& ((exPayload.instr.rs == wbCtl.writeRegNum && needsRs(exCtl))
			|| (exPayload.instr.rt == wbCtl.writeRegNum && needsRt(exCtl)));
	assign needStallWB = wbWrites && wbFeedsEx && (needStallEx || needStallMA);

	// a stage stalls when it needs to or when anything after it is stalled
	// the stage after a stalling one is cleared unless it is itself held
	assign stallWB = needStallWB;
	assign clearWB = needStallMA && !stallWB;

	assign stallMA = needStallMA || stallWB;
	assign clearMA = needStallEx && !stallMA;

	assign stallEx = needStallEx || stallMA;
	assign clearEx = (needStallDe || iStall) && !stallEx;

	// the instruction cache stall holds decode since nothing new can arrive
	assign stallDe = needStallDe || stallEx || iStall;
	assign clearDe = exception && !stallDe;

	// fetch may hand over an instruction only when decode will load it
	assign fetchReady = !stallDe && !iStall && !exception;

endmodule

/* src/tigerPipeCtrl.sv */
module tigerPipeCtrl (
	input  logic clk,
	input  logic reset,
	input  logic fetchValid,
	input  tigerPkg::controlT fetchControl,
	input  tigerPkg::instrT fetchInstr,
	input  logic iStall,
	input  logic cpuHold,
	input  logic exception,
	output logic fetchReady,
	output logic retireValid,
	output logic [15:0] retireTag,
	output logic retireWriteEn,
	output tigerPkg::regNumT retireWriteRegNum
);
	import tigerPkg::*;

	decodePayloadT fetchPayload;
	decodePayloadT dePayload;
	decodePayloadT exPayload;
	decodePayloadT maPayload;
	decodePayloadT wbPayload;
	logic deValid;
	logic exValid;
	logic maValid;
	logic wbValid;
	logic stallDe;
	logic clearDe;
	logic stallEx;
	logic clearEx;
	logic stallMA;
	logic clearMA;
	logic stallWB;
	logic clearWB;
	logic dStall;
	logic stallRqEx;
	logic timerStart;
	logic [TIMER_WIDTH-1:0] timerLoad;
	logic timerBusy;
	logic timerDone;

	assign fetchPayload = '{control: fetchControl, instr: fetchInstr};

	// decode loads fetchValid directly, when it loads fetchReady is high
	tigerStageReg #(.payloadT(decodePayloadT)) u_deReg (
		.clk(clk), .reset(reset), .stall(stallDe), .clear(clearDe),
		.inValid(fetchValid), .inPayload(fetchPayload),
		.valid(deValid), .payload(dePayload)
	);

	tigerStageReg #(.payloadT(decodePayloadT)) u_exReg (
		.clk(clk), .reset(reset), .stall(stallEx), .clear(clearEx),
		.inValid(deValid), .inPayload(dePayload),
		.valid(exValid), .payload(exPayload)
	);

	tigerStageReg #(.payloadT(decodePayloadT)) u_maReg (
		.clk(clk), .reset(reset), .stall(stallMA), .clear(clearMA),
		.inValid(exValid), .inPayload(exPayload),
		.valid(maValid), .payload(maPayload)
	);

	tigerStageReg #(.payloadT(decodePayloadT)) u_wbReg (
		.clk(clk), .reset(reset), .stall(stallWB), .clear(clearWB),
		.inValid(maValid), .inPayload(maPayload),
		.valid(wbValid), .payload(wbPayload)
	);

	tigerStallLogic u_stallLogic (
		.deValid(deValid), .exValid(exValid), .maValid(maValid), .wbValid(wbValid),
		.dePayload(dePayload), .exPayload(exPayload),
		.maPayload(maPayload), .wbPayload(wbPayload),
		.iStall(iStall), .cpuHold(cpuHold), .exception(exception),
		.dStall(dStall), .stallRqEx(stallRqEx),
		.stallDe(stallDe), .clearDe(clearDe), .stallEx(stallEx), .clearEx(clearEx),
		.stallMA(stallMA), .clearMA(clearMA), .stallWB(stallWB), .clearWB(clearWB),
		.fetchReady(fetchReady)
	);

	tigerStallSequencer u_sequencer (
		.clk(clk), .reset(reset), .maValid(maValid), .exValid(exValid),
		.maPayload(maPayload), .exPayload(exPayload),
		.stallMA(stallMA), .stallEx(stallEx),
		.timerBusy(timerBusy), .timerDone(timerDone),
		.timerStart(timerStart), .timerLoad(timerLoad),
		.dStall(dStall), .stallRqEx(stallRqEx)
	);

	tigerCountdownTimer u_timer (
		.clk(clk), .reset(reset), .start(timerStart), .load(timerLoad),
		.busy(timerBusy), .done(timerDone)
	);

	// an instruction retires in the one cycle its WB slot is valid and not held
	assign retireValid = wbValid && !stallWB;
	assign retireTag = wbPayload.instr.tag;
	assign retireWriteEn = wbPayload.control.regWrite;
	assign retireWriteRegNum = wbPayload.control.writeRegNum;

endmodule

/* verification/tigerStall_properties.sv */
module tigerStall_properties (
	input logic clk,
	input logic reset,
	input logic deValid,
	input logic exValid,
	input logic maValid,
	input logic wbValid,
	input tigerPkg::decodePayloadT dePayload,
	input tigerPkg::decodePayloadT exPayload,
	input tigerPkg::decodePayloadT maPayload,
	input tigerPkg::decodePayloadT wbPayload,
	input logic stallDe,
	input logic stallEx,
	input logic stallMA,
	input logic stallWB,
	input logic dStall
);
	timeunit 1ns;
	timeprecision 100ps;
	import tigerPkg::*;

	// a held slot keeps its instruction and so does the slot in front of it
	assert property (@(posedge clk) disable iff (reset)
		stallWB |=> $stable(wbValid) && $stable(wbPayload)
			&& $stable(maValid) && $stable(maPayload))
	else $error("WB held while WB or MA changed");
	assert property (@(posedge clk) disable iff (reset)
		stallMA |=> $stable(maValid) && $stable(maPayload)
			&& $stable(exValid) && $stable(exPayload))
	else $error("MA held while MA or Ex changed");
	assert property (@(posedge clk) disable iff (reset)
		stallEx |=> $stable(exValid) && $stable(exPayload)
			&& $stable(deValid) && $stable(dePayload))
	else $error("Ex held while Ex or De changed");
	assert property (@(posedge clk) disable iff (reset)
		stallDe |=> $stable(deValid) && $stable(dePayload))
	else $error("De held while De changed");

	// the slot behind the last held stage becomes a bubble, so nothing is duplicated
	assert property (@(posedge clk) disable iff (reset) stallMA && !stallWB |=> !wbValid)
	else $error("WB not cleared behind a held MA");
	assert property (@(posedge clk) disable iff (reset) stallEx && !stallMA |=> !maValid)
	else $error("MA not cleared behind a held Ex");
	assert property (@(posedge clk) disable iff (reset) stallDe && !stallEx |=> !exValid)
	else $error("Ex not cleared behind a held De");

	// one miss keeps dStall up for exactly the miss latency
	assert property (@(posedge clk) disable iff (reset)
		$rose(dStall) |-> ##MISS_LATENCY !dStall)
	else $error("dStall too long");
	assert property (@(posedge clk) disable iff (reset)
		$fell(dStall) |-> $past(dStall, MISS_LATENCY) && !$past(dStall, MISS_LATENCY + 1))
	else $error("dStall too short");

endmodule

// the top level carries the clock, the stage contents and the stall controls as plain wires
bind tigerPipeCtrl tigerStall_properties u_stallProperties (.*);

/* verification/tigerPipeCtrlTb.sv */
module tigerPipeCtrlTb;
	timeunit 1ns;
	timeprecision 100ps;
	import tigerPkg::*;

	localparam int PROG_LEN = 200;
	// the first part runs without external stalls so that retire gaps are exact bounds
	localparam int PHASE1_LEN = 150;

	typedef struct packed {
		logic [15:0] tag;
		logic writeEn;
		regNumT regNum;
		int minGap;
	} expectT;

	logic clk = 1'b0;
	logic reset;
	logic fetchValid;
	controlT fetchControl;
	instrT fetchInstr;
	logic iStall;
	logic cpuHold;
	logic exception;
	logic fetchReady;
	logic retireValid;
	logic [15:0] retireTag;
	logic retireWriteEn;
	regNumT retireWriteRegNum;

	controlT progCtl [PROG_LEN];
	instrT progInstr [PROG_LEN];
	bit cleanOf [PROG_LEN];
	bit gapCheck [PROG_LEN];
	int acceptCycle [PROG_LEN];
	int expQ [$];
	int genCount = 0;
	int offerIdx = -1;
	int cycle = 0;
	int acceptedCount = 0;
	int lastRetireCycle = 0;
	int lastRetireIdx = -1;
	int stallLeft = 0;
	int errorCount = 0;
	bit lastAccepted = 1'b0;

	tigerPipeCtrl u_tigerPipeCtrl (.*);

	always #4 clk = !clk;

	task automatic failValue(input string msg);
		errorCount++;
		$display("** Error at %0t ns: %s", $time, msg);
		$display("=== FAIL ===");
		$fatal(1, "stopping at first error");
	endtask

	// expected retire fields and the shortest legal gap behind the previous instruction
	function automatic expectT expectOf(input int idx);
		expectT e;
		controlT c;
		controlT p;
		c = progCtl[idx];
		e.tag = progInstr[idx].tag;
		e.writeEn = c.regWrite;
		e.regNum = c.writeRegNum;
		e.minGap = 1;
		if (idx > 0)
		begin
			p = progCtl[idx - 1];
			if (c.memMiss)
				e.minGap = MISS_LATENCY + 1;
			else if (c.mulOp)
				e.minGap = MUL_LATENCY + 1;
			else if (c.branch && p.regWrite && p.writeRegNum != '0
				&& progInstr[idx].rs == p.writeRegNum)
				e.minGap = 3;
			else if (p.memRead && p.regWrite && p.writeRegNum != '0
				&& progInstr[idx].rs == p.writeRegNum)
				e.minGap = 2;
		end
		return e;
	endfunction

	task automatic appendInstr(input controlT ctl, input regNumT rs, input regNumT rt,
		input bit clean);
		if (genCount < PROG_LEN)
		begin
			progCtl[genCount] = ctl;
			progInstr[genCount] = '{rs: rs, rt: rt, tag: 16'(genCount)};
			cleanOf[genCount] = clean;
			gapCheck[genCount] = genCount > 0 && genCount < PHASE1_LEN;
			genCount++;
		end
	endtask

	// a writer with no register sources, used ahead of misses and multiplies
	function automatic controlT writerCtl();
		controlT c;
		c = '0;
		c.regWrite = 1'b1;
		c.useImm = 1'b1;
		c.writeRegNum = regNumT'(1 + $urandom % 7);
		return c;
	endfunction

	task automatic buildProgram();
		controlT c;
		regNumT d;
		while (genCount < PROG_LEN)
		begin
			c = writerCtl();
			d = c.writeRegNum;
			case ($urandom % 7)
				0:
				begin
					c.regWrite = 1'($urandom % 2);
					c.useImm = 1'($urandom % 2);
					appendInstr(c, regNumT'($urandom % 8), regNumT'($urandom % 8), 1'b0);
				end
				1:
				begin
					repeat (5) appendInstr(writerCtl(), '0, '0, 1'b1);
				end
				2:
				begin
					c.memRead = 1'b1;
					appendInstr(c, '0, '0, 1'b0);
					appendInstr(writerCtl(), d, '0, 1'b0);
				end
				3:
				begin
					appendInstr(c, '0, '0, 1'b0);
					c = '0;
					c.branch = 1'b1;
					c.branchEqNe = 1'($urandom % 2);
					appendInstr(c, d, d, 1'b0);
				end
				4:
				begin
					appendInstr(c, '0, '0, 1'b0);
					c = writerCtl();
					c.memRead = 1'b1;
					c.memMiss = 1'b1;
					appendInstr(c, '0, '0, 1'b0);
					// the instruction behind a miss reads nothing that WB would have to keep
					appendInstr(writerCtl(), '0, '0, 1'b0);
				end
				5:
				begin
					appendInstr(c, '0, '0, 1'b0);
					c = writerCtl();
					c.mulOp = 1'b1;
					appendInstr(c, '0, '0, 1'b0);
				end
				default:
				begin
					c.regWrite = 1'b0;
					c.copWrite = 1'b1;
					appendInstr(c, '0, '0, 1'b0);
					c = writerCtl();
					c.copRead = 1'b1;
					appendInstr(c, '0, '0, 1'b0);
				end
			endcase
		end
	endtask

	task automatic checkRetire();
		int idx;
		expectT e;
		assert (expQ.size() != 0) else failValue("retire with no instruction outstanding");
		idx = expQ.pop_front();
		e = expectOf(idx);
		assert (retireTag == e.tag)
		else failValue($sformatf("tag %0h, expected %0h", retireTag, e.tag));
		assert (retireWriteEn == e.writeEn)
		else failValue($sformatf("write enable wrong on tag %0h", e.tag));
		assert (retireWriteRegNum == e.regNum)
		else failValue($sformatf("register %0d, expected %0d", retireWriteRegNum, e.regNum));
		if (gapCheck[idx] && lastRetireIdx == idx - 1)
			assert (cycle - lastRetireCycle >= e.minGap)
			else failValue($sformatf("tag %0h retired %0d cycles after its predecessor, minimum %0d",
				e.tag, cycle - lastRetireCycle, e.minGap));
		if (idx >= 3 && idx < PHASE1_LEN && cleanOf[idx] && cleanOf[idx - 1]
			&& cleanOf[idx - 2] && cleanOf[idx - 3])
			assert (cycle - acceptCycle[idx] == 4)
			else failValue($sformatf("tag %0h latency %0d, expected 4", e.tag,
				cycle - acceptCycle[idx]));
		lastRetireCycle = cycle;
		lastRetireIdx = idx;
	endtask

	// compare process, inputs change only on the falling edge so everything is stable here
	always @(posedge clk)
	begin
		cycle++;
		if (!reset)
		begin
			lastAccepted = fetchValid && fetchReady;
			if (iStall || exception)
				assert (!fetchReady) else failValue("fetchReady high during iStall or exception");
			if (acceptedCount == 0 && !iStall && !exception)
				assert (fetchReady) else failValue("fetchReady low on an empty pipeline");
			if (retireValid)
				checkRetire();
			if (lastAccepted)
			begin
				assert (offerIdx >= 0) else failValue("instruction accepted during exception");
				expQ.push_back(offerIdx);
				acceptCycle[offerIdx] = cycle;
				acceptedCount++;
			end
		end
	end

	// random stretches of iStall or cpuHold
	task automatic driveStalls();
		if (stallLeft > 0)
		begin
			stallLeft--;
		end
		else
		begin
			iStall = 1'b0;
			cpuHold = 1'b0;
			if ($urandom % 4 == 0)
			begin
				stallLeft = $urandom % 5;
				if ($urandom % 2)
					iStall = 1'b1;
				else
					cpuHold = 1'b1;
			end
		end
	endtask

	task automatic runPhase(input int first, input int last, input bit withStalls);
		int idx;
		idx = first;
		@(negedge clk);
		while (idx < last)
		begin
			fetchValid = 1'b1;
			fetchControl = progCtl[idx];
			fetchInstr = progInstr[idx];
			offerIdx = idx;
			if (withStalls)
				driveStalls();
			@(negedge clk);
			if (lastAccepted)
				idx++;
		end
		fetchValid = 1'b0;
		iStall = 1'b0;
		cpuHold = 1'b0;
	endtask

	task automatic drainPipe();
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	// anything offered while the exception is up must be dropped
	task automatic exceptionTest();
		@(negedge clk);
		exception = 1'b1;
		fetchValid = 1'b1;
		fetchInstr.tag = 16'hffff;
		offerIdx = -1;
		repeat (4) @(negedge clk);
		exception = 1'b0;
		fetchValid = 1'b0;
	endtask

	initial
	begin
		void'($urandom(89));
		reset = 1'b1;
		fetchValid = 1'b0;
		fetchControl = '0;
		fetchInstr = '0;
		iStall = 1'b0;
		cpuHold = 1'b0;
		exception = 1'b0;
		buildProgram();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		runPhase(0, PHASE1_LEN, 1'b0);
		drainPipe();
		runPhase(PHASE1_LEN, PROG_LEN, 1'b1);
		drainPipe();
		exceptionTest();
		drainPipe();
		if (errorCount == 0 && acceptedCount == PROG_LEN)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
		begin
			$display("accepted %0d instructions, expected %0d", acceptedCount, PROG_LEN);
			$display("=== FAIL ===");
			$fatal(1, "instruction count mismatch");
		end
	end

	// worst case per instruction is a full miss plus the pipeline depth
	initial
	begin
		#((PROG_LEN * (MISS_LATENCY + 8) + 16) * 8);
		$display("simulation hang, instructions did not retire before the time limit");
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

endmodule

/* flist.f */
src/tigerPkg.sv
src/tigerStageReg.sv
src/tigerCountdownTimer.sv
src/tigerStallSequencer.sv
src/tigerStallLogic.sv
src/tigerPipeCtrl.sv
verification/tigerStall_properties.sv
verification/tigerPipeCtrlTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tigerPipeCtrlTb -o simv

# the simulator exits nonzero on a failure, the log decides the result
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	exit 1
fi
exit 0
